// ==== Bender.yml ====
package:
  name: fetch_front_end

dependencies: {}

sources:
  - files:
      - logic/fetch_pkg.sv
      - logic/fetch_ctrl.sv
      - logic/prefetch_queue.sv
      - logic/ip_counter.sv
      - logic/immediate_reader.sv
      - logic/fetch_front_end.sv
  - target: simulation
    files:
      - dv/fetch_front_end_tb.sv

// ==== dv/fetch_front_end_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end_tb;

    localparam int QUEUE_DEPTH = 6;
    localparam int MAX_CMDS = 64;
    // Long enough for any three accesses to land
    localparam int FILL_CYCLES = 40;

    logic clk;
    logic rst;
    fetch_pkg::cs_ip_load_t cs_ip_load;
    fetch_pkg::instr_req_t instr_req;
    fetch_pkg::instr_rsp_t instr_rsp = '0;
    logic byte_rd_en;
    fetch_pkg::byte_t byte_data;
    logic byte_empty;
    fetch_pkg::immed_req_t immed_req;
    logic immed_busy;
    logic immed_complete;
    fetch_pkg::word_t immediate;
    fetch_pkg::word_t ip_current;

    // Command table
    logic [63:0] cmd_name [MAX_CMDS];
    logic [31:0] cmd_a [MAX_CMDS];
    logic [31:0] cmd_b [MAX_CMDS];
    int num_cmds = 0;
    logic cmds_ready = 1'b0;

    // Segment and offset of the next byte to be consumed
    logic [15:0] exp_cs;
    logic [15:0] exp_ip;

    // Bus side memory model
    logic [31:0] rng;
    logic [15:0] bus_cs;
    logic [15:0] bus_off;
    logic [19:0] bus_phys;
    logic [19:1] bus_addr;
    logic bus_waiting;
    logic bus_stale;
    int bus_wait_cnt;

    fetch_front_end #(
        .queue_depth (QUEUE_DEPTH)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .cs_ip_load     (cs_ip_load),
        .instr_req      (instr_req),
        .instr_rsp      (instr_rsp),
        .byte_rd_en     (byte_rd_en),
        .byte_data      (byte_data),
        .byte_empty     (byte_empty),
        .immed_req      (immed_req),
        .immed_busy     (immed_busy),
        .immed_complete (immed_complete),
        .immediate      (immediate),
        .ip_current     (ip_current)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Segment times 16 plus offset modulo 1MB
    function automatic logic [19:0] phys_addr(input logic [15:0] seg, input logic [15:0] off);
        logic [31:0] sum;
        sum = 32'(seg) * 32'd16 + 32'(off);
        return sum[19:0];
    endfunction

    function automatic logic [7:0] mem_byte(input logic [15:0] seg, input logic [15:0] off);
        logic [19:0] p;
        logic [15:0] w;
        p = phys_addr(seg, off);
        w = p[16:1] ^ 16'h5a3c;
        return p[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic read_stimulus();
        int fd;
        int fields;
        logic [8*128-1:0] line;
        logic [63:0] keyword;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("dv/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file dv/fetch_stimulus.txt");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            line = '0;
            keyword = '0;
            a = '0;
            b = '0;
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s", keyword);
                if (fields == 1 && keyword != "#") begin
                    if (keyword == "BYTES")
                        fields = $sscanf(line, "%s %d %h", keyword, a, b);
                    else if (keyword == "HOLD")
                        fields = $sscanf(line, "%s %d", keyword, a);
                    else
                        fields = $sscanf(line, "%s %h %h", keyword, a, b);
                    if (num_cmds == MAX_CMDS) begin
                        $display("The stimulus file holds more than %0d commands", MAX_CMDS);
                        stop_with_failure();
                    end
                    cmd_name[num_cmds] = keyword;
                    cmd_a[num_cmds] = a;
                    cmd_b[num_cmds] = b;
                    num_cmds++;
                end
            end
        end
        $fclose(fd);
        cmds_ready = 1'b1;
    endtask

    task automatic load_cs_ip(input logic [15:0] cs, input logic [15:0] ip);
        cs_ip_load <= {1'b1, cs, ip};
        @(posedge clk);
        cs_ip_load.load <= 1'b0;
        exp_cs = cs;
        exp_ip = ip;
        @(posedge clk);
        check_equal(ip_current, ip, "ip_current after a load");
        check_equal(byte_empty, 1, "queue emptied by a load");
    endtask

    // Holds the read strobe and takes a byte at every edge with a non-empty queue
    task automatic read_bytes(input int count, input logic [7:0] first_expected);
        int taken;
        taken = 0;
        byte_rd_en <= 1'b1;
        while (taken < count) begin
            @(posedge clk);
            if (!byte_empty) begin
                check_equal(ip_current, exp_ip, "ip_current before a byte read");
                check_equal(byte_data, mem_byte(exp_cs, exp_ip), "byte at the current ip");
                if (taken == 0)
                    check_equal(byte_data, first_expected, "first byte given in the stimulus");
                exp_ip = exp_ip + 16'd1;
                taken++;
            end
        end
        byte_rd_en <= 1'b0;
    endtask

    task automatic read_immediate(input logic is8, input logic [15:0] file_value);
        logic [15:0] expected;
        if (is8)
            expected = {8'h00, mem_byte(exp_cs, exp_ip)};
        else
            expected = {mem_byte(exp_cs, exp_ip + 16'd1), mem_byte(exp_cs, exp_ip)};
        immed_req.start <= 1'b1;
        immed_req.is_8bit <= is8;
        @(posedge clk);
        immed_req.start <= 1'b0;
        @(posedge clk);
        check_equal(immed_busy, 1, "immed_busy after start");
        while (!immed_complete)
            @(posedge clk);
        exp_ip = exp_ip + (is8 ? 16'd1 : 16'd2);
        check_equal(immediate, expected, "immediate from the queued bytes");
        check_equal(immediate, file_value, "immediate given in the stimulus");
        check_equal(ip_current, exp_ip, "ip_current after an immediate");
        @(posedge clk);
        check_equal(immed_complete, 0, "immed_complete lasting one cycle");
        check_equal(immed_busy, 0, "immed_busy after completion");
    endtask

    task automatic hold_cycles(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (i >= FILL_CYCLES)
                check_equal(instr_req.access, 0, "access while the queue is nearly full");
        end
        check_equal(ip_current, exp_ip, "ip_current after a hold");
    endtask

    // Instruction memory with a random ack delay of 0 to 5 cycles
    always @(posedge clk) begin
        if (rst) begin
            instr_rsp <= '0;
            rng = 32'ha472ee94;
            bus_cs = 16'hffff;
            bus_off = 16'h0000;
            bus_waiting = 1'b0;
            bus_stale = 1'b0;
            bus_wait_cnt = 0;
        end else begin
            if (instr_rsp.ack) begin
                instr_rsp.ack <= 1'b0;
                // Discarded words leave the offset alone
                if (!bus_stale && !cs_ip_load.load) begin
                    // Odd offset used only the upper byte
                    if (bus_off[0])
                        bus_off = bus_off + 16'd1;
                    else
                        bus_off = bus_off + 16'd2;
                end
                bus_stale = 1'b0;
            end else if (instr_req.access) begin
                if (!bus_waiting) begin
                    bus_phys = phys_addr(bus_cs, bus_off);
                    bus_addr = bus_phys[19:1];
                    check_equal(instr_req.addr, bus_addr, "instruction bus address");
                    rng = xorshift32(rng);
                    bus_wait_cnt = rng % 6;
                    bus_waiting = 1'b1;
                end else begin
                    check_equal(instr_req.addr, bus_addr, "address held during an access");
                    if (bus_wait_cnt == 0) begin
                        instr_rsp.ack <= 1'b1;
                        instr_rsp.data <= bus_addr[16:1] ^ 16'h5a3c;
                        bus_waiting = 1'b0;
                    end else begin
                        bus_wait_cnt--;
                    end
                end
            end
            if (cs_ip_load.load) begin
                bus_cs = cs_ip_load.cs;
                bus_off = cs_ip_load.ip;
                bus_stale = instr_req.access && !instr_rsp.ack;
            end
        end
    end

    initial begin
        wait (cmds_ready);
        repeat (64 * num_cmds + 200) @(posedge clk);
        $display("Timeout: the commands did not finish within %0d cycles",
                 64 * num_cmds + 200);
        stop_with_failure();
    end

    initial begin
        rst = 1'b1;
        cs_ip_load = '0;
        byte_rd_en = 1'b0;
        immed_req = '0;
        exp_cs = 16'hffff;
        exp_ip = 16'h0000;
        read_stimulus();
        repeat (5) @(posedge clk);
        check_equal(instr_req.access, 0, "access during reset");
        check_equal(byte_empty, 1, "byte_empty during reset");
        check_equal(immed_busy, 0, "immed_busy during reset");
        check_equal(immed_complete, 0, "immed_complete during reset");
        check_equal(ip_current, 16'h0000, "ip_current during reset");
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_equal(instr_req.access, 1, "access in the first cycle after reset");
        for (int i = 0; i < num_cmds; i++) begin
            case (cmd_name[i])
                "LOAD": load_cs_ip(cmd_a[i][15:0], cmd_b[i][15:0]);
                "BYTES": read_bytes(cmd_a[i], cmd_b[i][7:0]);
                "IMM8": read_immediate(1'b1, cmd_a[i][15:0]);
                "IMM16": read_immediate(1'b0, cmd_a[i][15:0]);
                "HOLD": hold_cycles(cmd_a[i]);
                default: begin
                    $display("Command %0d of the stimulus file is not known", i);
                    stop_with_failure();
                end
            endcase
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/fetch_stimulus.txt ====
# Commands: LOAD cs ip | BYTES count first | IMM8 value | IMM16 value | HOLD cycles
# cs, ip, first and value are hex; count and cycles are decimal
BYTES 3 c4
IMM8 00a5
IMM16 a5c6
BYTES 2 c7
HOLD 56
BYTES 4 c0
LOAD 1234 0057
BYTES 3 cb
IMM16 cbf1
IMM8 00f2
HOLD 56
BYTES 2 cb
LOAD 0800 0003
HOLD 2
LOAD 2000 0011
BYTES 4 5a
IMM16 375a
LOAD f000 fffe
BYTES 3 c3
LOAD ffff fff5
BYTES 3 25
IMM8 00c8
HOLD 56

// ==== list.f ====
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/prefetch_queue.sv
logic/ip_counter.sv
logic/immediate_reader.sv
logic/fetch_front_end.sv
dv/fetch_front_end_tb.sv

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  fetch_pkg::cs_ip_load_t   cs_ip_load,
    output fetch_pkg::instr_req_t    instr_req,
    input  fetch_pkg::instr_rsp_t    instr_rsp,
    output logic                     queue_wr_en,
    output fetch_pkg::byte_t         queue_wr_data,
    input  logic                     queue_nearly_full
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WRITE_LO,
        WRITE_HI
    } state_t;

    state_t state;
    fetch_pkg::word_t cs_reg;
    fetch_pkg::word_t fetch_offset;
    fetch_pkg::word_t fetched_word;
    fetch_pkg::phys_word_addr_t addr_reg;
    logic stale;

    // cs * 16 + offset, wrapping at 1MB, word aligned
    function automatic fetch_pkg::phys_word_addr_t word_addr(
        input fetch_pkg::word_t seg,
        input fetch_pkg::word_t off
    );
        logic [19:0] phys;
        phys = {seg, 4'h0} + {4'h0, off};
        return phys[19:1];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cs_reg <= fetch_pkg::RESET_CS;
            fetch_offset <= fetch_pkg::RESET_IP;
            stale <= 1'b0;
        end else if (cs_ip_load.load) begin
            cs_reg <= cs_ip_load.cs;
            fetch_offset <= cs_ip_load.ip;
            if (state == ACCESS) begin
                // Bus cycle must finish, its data is dropped
                if (instr_rsp.ack) begin
                    state <= IDLE;
                    stale <= 1'b0;
                end else begin
                    stale <= 1'b1;
                end
            end else begin
                // Queue is flushed, so there is room
                state <= ACCESS;
                stale <= 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (!queue_nearly_full)
                        state <= ACCESS;
                end
                ACCESS: begin
                    if (instr_rsp.ack) begin
                        stale <= 1'b0;
                        if (stale)
                            state <= IDLE;
                        else if (fetch_offset[0])
                            state <= WRITE_HI;
                        else
                            state <= WRITE_LO;
                    end
                end
                WRITE_LO: begin
                    state <= WRITE_HI;
                end
                WRITE_HI: begin
                    // Next even offset
                    fetch_offset <= {fetch_offset[15:1], 1'b0} + 16'd2;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address held stable for the whole access
    always_ff @(posedge clk) begin
        if (cs_ip_load.load && state != ACCESS)
            addr_reg <= word_addr(cs_ip_load.cs, cs_ip_load.ip);
        else if (state == IDLE && !queue_nearly_full)
            addr_reg <= word_addr(cs_reg, fetch_offset);
    end

    always_ff @(posedge clk) begin
        if (state == ACCESS && instr_rsp.ack)
            fetched_word <= instr_rsp.data;
    end

    assign instr_req.access = (state == ACCESS);
    assign instr_req.addr = addr_reg;

    assign queue_wr_en = (state == WRITE_LO) || (state == WRITE_HI);
    assign queue_wr_data = (state == WRITE_LO) ? fetched_word[7:0] : fetched_word[15:8];

endmodule

`default_nettype wire

// ==== logic/fetch_front_end.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end #(
    parameter int queue_depth = fetch_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::cs_ip_load_t cs_ip_load,
    output fetch_pkg::instr_req_t  instr_req,
    input  fetch_pkg::instr_rsp_t  instr_rsp,
    input  logic                   byte_rd_en,
    output fetch_pkg::byte_t       byte_data,
    output logic                   byte_empty,
    input  fetch_pkg::immed_req_t  immed_req,
    output logic                   immed_busy,
    output logic                   immed_complete,
    output fetch_pkg::word_t       immediate,
    output fetch_pkg::word_t       ip_current
);

    logic queue_wr_en;
    fetch_pkg::byte_t queue_wr_data;
    logic queue_nearly_full;
    logic queue_rd_en;
    fetch_pkg::byte_t queue_rd_data;
    logic queue_empty;
    logic immed_rd_en;
    logic ip_inc;

    // Opcode port and immediate reader share the queue
    assign queue_rd_en = byte_rd_en | immed_rd_en;
    // Count only bytes that were really taken
    assign ip_inc = queue_rd_en & ~queue_empty;

    assign byte_data = queue_rd_data;
    assign byte_empty = queue_empty;

    fetch_ctrl u_fetch_ctrl (
        .clk               (clk),
        .rst               (rst),
        .cs_ip_load        (cs_ip_load),
        .instr_req         (instr_req),
        .instr_rsp         (instr_rsp),
        .queue_wr_en       (queue_wr_en),
        .queue_wr_data     (queue_wr_data),
        .queue_nearly_full (queue_nearly_full)
    );

    prefetch_queue #(
        .queue_depth (queue_depth)
    ) u_prefetch_queue (
        .clk         (clk),
        .rst         (rst),
        .flush       (cs_ip_load.load),
        .wr_en       (queue_wr_en),
        .wr_data     (queue_wr_data),
        .rd_en       (queue_rd_en),
        .rd_data     (queue_rd_data),
        .empty       (queue_empty),
        .nearly_full (queue_nearly_full)
    );

    ip_counter u_ip_counter (
        .clk        (clk),
        .rst        (rst),
        .cs_ip_load (cs_ip_load),
        .inc        (ip_inc),
        .ip_current (ip_current)
    );

    immediate_reader u_immediate_reader (
        .clk           (clk),
        .rst           (rst),
        .immed_req     (immed_req),
        .busy          (immed_busy),
        .complete      (immed_complete),
        .immediate     (immediate),
        .queue_rd_en   (immed_rd_en),
        .queue_rd_data (queue_rd_data),
        .queue_empty   (queue_empty)
    );

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Basic widths
    typedef logic [7:0] byte_t;
    typedef logic [15:0] word_t;

    // Physical address bits 19:1 of a bus word
    typedef logic [19:1] phys_word_addr_t;

    // Segment and offset load, redirects fetch
    typedef struct packed {
        logic load;
        word_t cs;
        word_t ip;
    } cs_ip_load_t;

    // Instruction bus request from the front end
    typedef struct packed {
        logic access;
        phys_word_addr_t addr;
    } instr_req_t;

    // Instruction bus response from memory
    typedef struct packed {
        logic ack;
        word_t data;
    } instr_rsp_t;

    // Immediate read request
    typedef struct packed {
        logic start;
        logic is_8bit;
    } immed_req_t;

    // Values after reset
    localparam word_t RESET_CS = 16'hffff;
    localparam word_t RESET_IP = 16'h0000;

    // Prefetch queue size in bytes
    localparam int DEFAULT_QUEUE_DEPTH = 6;

endpackage

`default_nettype wire

// ==== logic/immediate_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module immediate_reader (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::immed_req_t immed_req,
    output logic                  busy,
    output logic                  complete,
    output fetch_pkg::word_t      immediate,
    output logic                  queue_rd_en,
    input  fetch_pkg::byte_t      queue_rd_data,
    input  logic                  queue_empty
);

    typedef enum logic [1:0] {
        IDLE,
        LOW_BYTE,
        HIGH_BYTE,
        DONE
    } state_t;

    state_t state;
    logic is_8bit;
    fetch_pkg::word_t immed_reg;
    logic reading;

    assign reading = (state == LOW_BYTE) || (state == HIGH_BYTE);

    // Pop as soon as a byte is there
    assign queue_rd_en = reading && !queue_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            is_8bit <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (immed_req.start) begin
                        state <= LOW_BYTE;
                        is_8bit <= immed_req.is_8bit;
                    end else begin
                        state <= IDLE;
                    end
                end
                LOW_BYTE: begin
                    if (!queue_empty)
                        state <= is_8bit ? DONE : HIGH_BYTE;
                end
                HIGH_BYTE: begin
                    if (!queue_empty)
                        state <= DONE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Little endian, 8-bit values zero extended
    always_ff @(posedge clk) begin
        if (state == LOW_BYTE && !queue_empty)
            immed_reg <= {8'h00, queue_rd_data};
        else if (state == HIGH_BYTE && !queue_empty)
            immed_reg[15:8] <= queue_rd_data;
    end

    assign busy = reading;
    assign complete = (state == DONE);
    assign immediate = immed_reg;

endmodule

`default_nettype wire

// ==== logic/ip_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module ip_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::cs_ip_load_t cs_ip_load,
    input  logic                   inc,
    output fetch_pkg::word_t       ip_current
);

    fetch_pkg::word_t ip_reg;

    always_ff @(posedge clk) begin
        if (rst)
            ip_reg <= fetch_pkg::RESET_IP;
        else if (cs_ip_load.load)
            ip_reg <= cs_ip_load.ip;
        else if (inc)
            ip_reg <= ip_reg + 16'd1;   // wraps within the segment
    end

    assign ip_current = ip_reg;

endmodule

`default_nettype wire

// ==== logic/prefetch_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module prefetch_queue #(
    parameter int queue_depth = fetch_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             wr_en,
    input  fetch_pkg::byte_t wr_data,
    input  logic             rd_en,
    output fetch_pkg::byte_t rd_data,
    output logic             empty,
    output logic             nearly_full
);

    localparam int ptr_bits = $clog2(queue_depth);
    localparam int count_bits = $clog2(queue_depth + 1);

    fetch_pkg::byte_t mem [queue_depth];
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] wr_ptr;
    logic [count_bits-1:0] count;
    logic full;
    logic do_rd;
    logic do_wr;

    assign full = (count == count_bits'(queue_depth));
    assign empty = (count == '0);
    // At most one free slot
    assign nearly_full = (count >= count_bits'(queue_depth - 1));

    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && !full;

    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_rd)
                rd_ptr <= (rd_ptr == ptr_bits'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr)
                wr_ptr <= (wr_ptr == ptr_bits'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr && !flush)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire
